//--- Makefile
# Verilator flow for the stream merger

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_stream_merge
RTL_TOP   ?= stream_merge_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing -j 0
PASS_MSG  ?= TB PASSED

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level on its own
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build and run, the pass line in the output decides the status
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TB_TOP)); echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- reg_read_queue.sv
`timescale 1ns/100ps

module reg_read_queue #(
        parameter type payload_t = logic [31:0],
        parameter int  DEPTH     = 8
) (
        input  logic                   clk,
        input  logic                   rst_n,
        // Producer side
        input  logic                   wr_en,
        input  payload_t               wr_beat,
        output logic                   full,
        output logic [$clog2(DEPTH):0] level,
        // Registered read side, data one cycle after rd_en
        input  logic                   rd_en,
        output payload_t               rd_beat,
        output logic                   not_empty
);

        localparam int AW = $clog2(DEPTH);

        payload_t      mem [DEPTH];
        logic [AW-1:0] wr_ptr;
        logic [AW-1:0] rd_ptr;
        logic          wr_ok;

        // ==============================================================
        // Flags
        // ==============================================================

        // Strobe while full is dropped here
        assign wr_ok     = wr_en && !full;
        // Both flags come straight from the level register
        assign full      = (level == (AW+1)'(DEPTH));
        assign not_empty = (level != '0);

        // ==============================================================
        // Pointers and fill counter
        // ==============================================================

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        level  <= '0;
                end else begin
                        // Pointers wrap on their own, DEPTH is a power of two
                        if (wr_ok) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (rd_en) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        case ({wr_ok, rd_en})
                                2'b10:   level <= level + 1'b1;
                                2'b01:   level <= level - 1'b1;
                                default: level <= level;
                        endcase
                end
        end

        // ==============================================================
        // Storage and read register
        // ==============================================================

        always_ff @(posedge clk) begin
                if (wr_ok) begin
                        mem[wr_ptr] <= wr_beat;
                end
                // Head word lands in the output register on the strobe
                if (rd_en) begin
                        rd_beat <= mem[rd_ptr];
                end
        end

        // Consumer must only strobe a queue that holds data
        a_no_read_when_empty : assert property (
                @(posedge clk) disable iff (!rst_n)
                rd_en |-> not_empty
        );

endmodule

//--- skid_fifo.sv
`timescale 1ns/100ps

module skid_fifo #(
        parameter type payload_t = logic [31:0],
        parameter int  DEPTH     = 4
) (
        input  logic                   clk,
        input  logic                   rst_n,
        // Write side
        input  logic                   wr_valid,
        output logic                   wr_ready,
        input  payload_t               wr_data,
        // Read side, head visible without a read strobe
        output logic                   rd_valid,
        input  logic                   rd_ready,
        output payload_t               rd_data,
        output logic [$clog2(DEPTH):0] count
);

        // DEPTH of two or more
        localparam int AW = $clog2(DEPTH);
        localparam int CW = AW + 1;

        payload_t      mem [DEPTH];
        logic [AW-1:0] wr_ptr;
        logic [AW-1:0] rd_ptr;
        logic          wr_fire;
        logic          rd_fire;

        // ==============================================================
        // Handshake
        // ==============================================================

        assign wr_ready = (count < CW'(DEPTH));
        assign rd_valid = (count != '0);
        // Fall-through head
        assign rd_data  = mem[rd_ptr];
        assign wr_fire  = wr_valid && wr_ready;
        assign rd_fire  = rd_valid && rd_ready;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        // Explicit wrap, depth need not be a power of two
                        if (wr_fire) begin
                                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
                        end
                        if (rd_fire) begin
                                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
                        end
                        case ({wr_fire, rd_fire})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (wr_fire) begin
                        mem[wr_ptr] <= wr_data;
                end
        end

        // Occupancy bounded by the storage over the whole run
        a_count_in_range : assert property (
                @(posedge clk) disable iff (!rst_n)
                count <= CW'(DEPTH)
        );

endmodule

//--- src.f
+incdir+.
stream_beat_pkg.sv
stream_status_pkg.sv
reg_read_queue.sv
skid_fifo.sv
stream_latency_bridge.sv
stream_rr_merge.sv
stream_merge_top.sv
tb_stream_merge.sv

//--- stream_beat_pkg.sv
`include "stream_cfg.svh"

package stream_beat_pkg;

        // ==============================================================
        // Beat formats on the channel and output streams
        // ==============================================================

        // One channel beat, data word plus end-of-packet marker
        typedef struct packed {
                logic [`STREAM_DATA_W-1:0] data;
                logic                      last;
        } beat_t;

        // Merged output beat
        // chan names the input channel that supplied the beat
        typedef struct packed {
                beat_t beat;
                logic  chan;
        } merged_beat_t;

endpackage

//--- stream_cfg.svh
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// ======================================================================
// Stream merger sizing
// ======================================================================

// Payload word width carried by every beat
`define STREAM_DATA_W 32

// Input queue depth per channel
// Must stay a power of two, the queue pointers wrap naturally
`define STREAM_Q_DEPTH 8

// Skid buffer depth behind each latency bridge
`define STREAM_SKID_DEPTH 4

// Output buffer depth in the round-robin merger
// Two entries keep one beat per cycle with out_ready high
`define STREAM_OUT_DEPTH 2

`endif

//--- stream_latency_bridge.sv
`timescale 1ns/100ps

`include "stream_cfg.svh"

module stream_latency_bridge #(
        parameter int DEPTH = `STREAM_SKID_DEPTH
) (
        input  logic                   clk,
        input  logic                   rst_n,
        // Upstream registered-read queue
        input  logic                   s_valid,
        output logic                   s_ready,
        input  stream_beat_pkg::beat_t s_beat,
        // Downstream valid/ready stream
        output logic                   m_valid,
        input  logic                   m_ready,
        output stream_beat_pkg::beat_t m_beat,
        // Beats held in the skid buffer
        output logic [2:0]             occupancy
);

        import stream_beat_pkg::*;

        localparam int CW = $clog2(DEPTH) + 1;

        logic          drain_ip;
        logic          skid_wr_ready;
        logic [CW-1:0] skid_count;
        logic [CW-1:0] pending;
        logic          room;
        logic          leaving;

        // ==============================================================
        // Room rule
        // ==============================================================

        // Beat in flight from the queue is still owed a slot
        assign pending = skid_count + {{(CW-1){1'b0}}, drain_ip};
        assign room    = (pending < CW'(DEPTH));
        // A beat leaving this cycle frees the slot for the next accept
        assign leaving = m_valid && m_ready;
        // Read strobe only toward a queue that holds data
        assign s_ready = s_valid && (room || leaving);

        // Accept now, queue data shows up next cycle
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        drain_ip <= 1'b0;
                end else begin
                        drain_ip <= s_valid && s_ready;
                end
        end

        // ==============================================================
        // Skid buffer
        // ==============================================================

        skid_fifo #(
                .payload_t (beat_t),
                .DEPTH     (DEPTH)
        ) i_skid (
                .clk      (clk),
                .rst_n    (rst_n),
                .wr_valid (drain_ip),
                .wr_ready (skid_wr_ready),
                .wr_data  (s_beat),
                .rd_valid (m_valid),
                .rd_ready (m_ready),
                .rd_data  (m_beat),
                .count    (skid_count)
        );

        assign occupancy = 3'(skid_count);

        // Room rule guarantees the in-flight beat always finds a slot
        a_skid_no_overflow : assert property (
                @(posedge clk) disable iff (!rst_n)
                drain_ip |-> skid_wr_ready
        );

endmodule

//--- stream_merge_top.sv
`timescale 1ns/100ps

`include "stream_cfg.svh"

module stream_merge_top (
        input  logic                            clk,
        input  logic                            rst_n,
        // Producer writes, one strobe per channel
        input  logic [1:0]                      wr_en,
        input  stream_beat_pkg::beat_t [1:0]    wr_beat,
        output logic [1:0]                      full,
        // Merged output stream
        output logic                            out_valid,
        input  logic                            out_ready,
        output stream_beat_pkg::merged_beat_t   out_beat,
        output stream_status_pkg::merge_status_t status
);

        import stream_beat_pkg::*;
        import stream_status_pkg::*;

        localparam int LW = $clog2(`STREAM_Q_DEPTH) + 1;

        // Queue to bridge
        logic [1:0]          not_empty;
        logic [1:0]          rd_en;
        beat_t [1:0]         rd_beat;
        logic [1:0][LW-1:0]  q_level;
        // Bridge to merger
        logic [1:0]          m_valid;
        logic [1:0]          m_ready;
        beat_t [1:0]         m_beat;
        logic [1:0][2:0]     occupancy;
        logic [1:0]          out_count;
        chan_status_t [1:0]  chan_stat;

        // ==============================================================
        // Per-channel queue and bridge
        // ==============================================================

        for (genvar i = 0; i < 2; i++) begin : g_chan
                reg_read_queue #(
                        .payload_t (beat_t),
                        .DEPTH     (`STREAM_Q_DEPTH)
                ) i_queue (
                        .clk       (clk),
                        .rst_n     (rst_n),
                        .wr_en     (wr_en[i]),
                        .wr_beat   (wr_beat[i]),
                        .full      (full[i]),
                        .level     (q_level[i]),
                        .rd_en     (rd_en[i]),
                        .rd_beat   (rd_beat[i]),
                        .not_empty (not_empty[i])
                );

                stream_latency_bridge #(
                        .DEPTH (`STREAM_SKID_DEPTH)
                ) i_bridge (
                        .clk       (clk),
                        .rst_n     (rst_n),
                        .s_valid   (not_empty[i]),
                        .s_ready   (rd_en[i]),
                        .s_beat    (rd_beat[i]),
                        .m_valid   (m_valid[i]),
                        .m_ready   (m_ready[i]),
                        .m_beat    (m_beat[i]),
                        .occupancy (occupancy[i])
                );

                // Fill report for this channel
                assign chan_stat[i] = '{q_level: q_level[i], bridge_occ: occupancy[i],
                                        full: full[i]};
        end

        // ==============================================================
        // Merger and status
        // ==============================================================

        stream_rr_merge i_merge (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (m_valid),
                .in_ready  (m_ready),
                .in_beat   (m_beat),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .out_beat  (out_beat),
                .out_count (out_count)
        );

        assign status = '{chan: chan_stat, out_count: out_count};

endmodule

//--- stream_rr_merge.sv
`timescale 1ns/100ps

`include "stream_cfg.svh"

module stream_rr_merge (
        input  logic                          clk,
        input  logic                          rst_n,
        // Two bridged channel streams
        input  logic [1:0]                    in_valid,
        output logic [1:0]                    in_ready,
        input  stream_beat_pkg::beat_t [1:0]  in_beat,
        // Tagged output stream
        output logic                          out_valid,
        input  logic                          out_ready,
        output stream_beat_pkg::merged_beat_t out_beat,
        output logic [1:0]                    out_count
);

        import stream_beat_pkg::*;

        logic         last_grant;
        logic         sel;
        logic [1:0]   grant;
        logic         push_ready;
        merged_beat_t push_beat;

        // ==============================================================
        // Round-robin select
        // ==============================================================

        always_comb begin
                // Contention goes to the channel that lost last time
                if (in_valid == 2'b11) begin
                        sel = ~last_grant;
                end else begin
                        sel = in_valid[1];
                end
                grant = 2'b00;
                if (|in_valid) begin
                        grant[sel] = 1'b1;
                end
        end

        // One-hot grant, qualified by output room
        assign in_ready = grant & {2{push_ready}};

        // Tag the winning beat with its channel
        assign push_beat.beat = in_beat[sel];
        assign push_beat.chan = sel;

        // Reset value makes channel 0 win the first contention
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        last_grant <= 1'b1;
                end else if (|in_ready) begin
                        last_grant <= sel;
                end
        end

        // ==============================================================
        // Output buffer
        // ==============================================================

        skid_fifo #(
                .payload_t (merged_beat_t),
                .DEPTH     (`STREAM_OUT_DEPTH)
        ) i_out_fifo (
                .clk      (clk),
                .rst_n    (rst_n),
                .wr_valid (|in_valid),
                .wr_ready (push_ready),
                .wr_data  (push_beat),
                .rd_valid (out_valid),
                .rd_ready (out_ready),
                .rd_data  (out_beat),
                .count    (out_count)
        );

        // Only one bridge may hand over a beat per cycle
        a_single_grant : assert property (
                @(posedge clk) disable iff (!rst_n)
                !(&in_ready)
        );

endmodule

//--- stream_status_pkg.sv
package stream_status_pkg;

        // ==============================================================
        // Fill and status reporting
        // ==============================================================

        // Per-channel fill report, 8 bits
        typedef struct packed {
                // Words waiting in the input queue
                logic [3:0] q_level;
                // Beats parked in the bridge skid buffer
                logic [2:0] bridge_occ;
                // Queue full, producer must hold off
                logic       full;
        } chan_status_t;

        // Whole subsystem status
        // Index 0 and 1 follow the channel numbers
        typedef struct packed {
                chan_status_t [1:0] chan;
                logic [1:0]         out_count;
        } merge_status_t;

endpackage

//--- tb_stream_merge.sv
`timescale 1ns/100ps

`include "stream_cfg.svh"

module tb_stream_merge;

        import stream_beat_pkg::*;
        import stream_status_pkg::*;

        localparam int TIMEOUT = 500;

        logic          clk;
        logic          rst_n;
        logic [1:0]    wr_en;
        beat_t [1:0]   wr_beat;
        logic [1:0]    full;
        logic          out_valid;
        logic          out_ready;
        merged_beat_t  out_beat;
        merge_status_t status;

        integer seed;
        int     errors;
        int     checks;
        int     tx_total;
        int     rx_total;
        int     test_err0;
        // Expected beats per channel in write order
        beat_t  exp_q0 [$];
        beat_t  exp_q1 [$];
        // Channel tags seen at the output while logging is on
        logic   log_chan;
        logic   chan_log [$];

        stream_merge_top i_dut (
                .clk       (clk),
                .rst_n     (rst_n),
                .wr_en     (wr_en),
                .wr_beat   (wr_beat),
                .full      (full),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .out_beat  (out_beat),
                .status    (status)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // ==================================================================
        // Helpers
        // ==================================================================

        task automatic check_eq(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("Mismatch at %0t: %s = 0x%0h, expected 0x%0h",
                                 $time, name, got, exp);
                end
        endtask

        // One write cycle, a channel is skipped while its full level is high
        task automatic write_cycle(input logic [1:0] mask, output int n);
                beat_t b;
                n = 0;
                for (int ch = 0; ch < 2; ch++) begin
                        if (mask[ch] && !full[ch]) begin
                                b.data = `STREAM_DATA_W'($random(seed));
                                b.last = 1'($random(seed));
                                wr_en[ch] = 1'b1;
                                wr_beat[ch] = b;
                                if (ch == 0) begin
                                        exp_q0.push_back(b);
                                end else begin
                                        exp_q1.push_back(b);
                                end
                                n++;
                        end
                end
                tx_total += n;
                @(posedge clk);
                #1;
                wr_en = 2'b00;
        endtask

        // Strobe into a full queue, the beat must not reach the output
        task automatic drop_write(input int ch);
                wr_en[ch] = 1'b1;
                wr_beat[ch] = '{data: `STREAM_DATA_W'($random(seed)), last: 1'b1};
                @(posedge clk);
                #1;
                wr_en = 2'b00;
        endtask

        task automatic wait_not_full(input logic [1:0] mask);
                int n;
                n = 0;
                while ((full & mask) != 2'b00 && n < TIMEOUT) begin
                        @(posedge clk);
                        #1;
                        n++;
                end
                if ((full & mask) != 2'b00) begin
                        errors++;
                        $display("Timeout at %0t: full level never dropped", $time);
                end
        endtask

        function automatic bit is_idle();
                return exp_q0.size() == 0 && exp_q1.size() == 0 && !out_valid &&
                       status == '0;
        endfunction

        task automatic wait_idle();
                int n;
                n = 0;
                while (!is_idle() && n < TIMEOUT) begin
                        @(posedge clk);
                        #1;
                        n++;
                end
                if (!is_idle()) begin
                        errors++;
                        $display("Timeout at %0t: subsystem did not drain to idle", $time);
                end
        endtask

        task automatic report_test(input string name);
                $display("%-14s %s, %0d errors", name,
                         (errors == test_err0) ? "ok" : "failed", errors - test_err0);
                test_err0 = errors;
        endtask

        // ==================================================================
        // Output monitor
        // ==================================================================

        // Sampled at the falling edge, the transfer lands on the next rising edge
        always @(negedge clk) begin
                beat_t exp;
                if (rst_n && out_valid && out_ready) begin
                        rx_total++;
                        if (log_chan) begin
                                chan_log.push_back(out_beat.chan);
                        end
                        if ((out_beat.chan == 1'b0 && exp_q0.size() == 0) ||
                            (out_beat.chan == 1'b1 && exp_q1.size() == 0)) begin
                                errors++;
                                $display("Unexpected beat on channel %0d at %0t",
                                         out_beat.chan, $time);
                        end else begin
                                exp = (out_beat.chan == 1'b0) ? exp_q0.pop_front() :
                                                                exp_q1.pop_front();
                                check_eq("out_beat.beat.data", 64'(out_beat.beat.data),
                                         64'(exp.data));
                                check_eq("out_beat.beat.last", 64'(out_beat.beat.last),
                                         64'(exp.last));
                        end
                end
        end

        // ==================================================================
        // Tests
        // ==================================================================

        task automatic reset_state();
                check_eq("out_valid", 64'(out_valid), 64'(0));
                check_eq("full", 64'(full), 64'(0));
                check_eq("status", 64'(status), 64'(0));
                report_test("reset_state");
        endtask

        task automatic single_stream();
                int cycles;
                int n;
                out_ready = 1'b1;
                write_cycle(2'b01, n);
                // Write edge counts as the first cycle
                cycles = 1;
                while (!out_valid && cycles < TIMEOUT) begin
                        @(posedge clk);
                        #1;
                        cycles++;
                end
                check_eq("first_beat_latency", 64'(cycles), 64'(4));
                for (int i = 1; i < 20; i++) begin
                        wait_not_full(2'b01);
                        write_cycle(2'b01, n);
                end
                wait_idle();
                report_test("single_stream");
        endtask

        task automatic dual_stream();
                int n;
                out_ready = 1'b1;
                chan_log.delete();
                log_chan = 1'b1;
                for (int i = 0; i < 12; i++) begin
                        wait_not_full(2'b11);
                        write_cycle(2'b11, n);
                end
                wait_idle();
                log_chan = 1'b0;
                check_eq("dual_beat_count", 64'(chan_log.size()), 64'(24));
                // Both channels always hold data, so tags must alternate
                for (int i = 1; i < chan_log.size(); i++) begin
                        check_eq("out_beat.chan", 64'(chan_log[i]), 64'(!chan_log[i-1]));
                end
                report_test("dual_stream");
        endtask

        task automatic backpressure();
                int n;
                int accepted;
                int guard;
                out_ready = 1'b0;
                accepted = 0;
                guard = 0;
                while (!full[0] && guard < TIMEOUT) begin
                        write_cycle(2'b01, n);
                        accepted += n;
                        guard++;
                end
                // Output buffer, then skid buffer, then queue
                check_eq("full[0]", 64'(full[0]), 64'(1));
                check_eq("accepted_beats", 64'(accepted),
                         64'(`STREAM_Q_DEPTH + `STREAM_SKID_DEPTH + `STREAM_OUT_DEPTH));
                check_eq("status.chan[0].bridge_occ", 64'(status.chan[0].bridge_occ),
                         64'(`STREAM_SKID_DEPTH));
                check_eq("status.out_count", 64'(status.out_count), 64'(`STREAM_OUT_DEPTH));
                drop_write(0);
                check_eq("status.chan[0].q_level", 64'(status.chan[0].q_level),
                         64'(`STREAM_Q_DEPTH));
                out_ready = 1'b1;
                wait_idle();
                report_test("backpressure");
        endtask

        task automatic random_ready();
                int sent;
                int n;
                int guard;
                logic [1:0] mask;
                sent = 0;
                guard = 0;
                while (sent < 60 && guard < TIMEOUT) begin
                        mask = 2'($random(seed));
                        out_ready = 1'($random(seed));
                        // Stop one short of two writes past the total
                        if (sent == 59) begin
                                mask[1] = 1'b0;
                        end
                        write_cycle(mask, n);
                        sent += n;
                        guard++;
                end
                check_eq("random_beats_sent", 64'(sent), 64'(60));
                out_ready = 1'b1;
                wait_idle();
                report_test("random_ready");
        endtask

        task automatic drain_idle();
                wait_idle();
                check_eq("out_valid", 64'(out_valid), 64'(0));
                check_eq("full", 64'(full), 64'(0));
                check_eq("status", 64'(status), 64'(0));
                check_eq("beats_received", 64'(rx_total), 64'(tx_total));
                report_test("drain_idle");
        endtask

        initial begin
                seed = 76428;
                errors = 0;
                checks = 0;
                tx_total = 0;
                rx_total = 0;
                test_err0 = 0;
                log_chan = 1'b0;
                rst_n = 1'b0;
                wr_en = 2'b00;
                wr_beat = '0;
                out_ready = 1'b0;
                repeat (5) @(posedge clk);
                #1;
                rst_n = 1'b1;
                reset_state();
                single_stream();
                dual_stream();
                backpressure();
                random_ready();
                drain_idle();
                $display("Checks %0d, errors %0d, beats %0d", checks, errors, rx_total);
                if (errors == 0) begin
                        $display("TB PASSED");
                end else begin
                        $display("TB FAILED");
                end
                $finish;
        end

endmodule
